// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

localparam int prog_words = 512;
localparam int data_words = 256;
// Word index where the final block dumps x1 to x31
localparam int dump_base  = 64;

logic [31:0] lcg_state;
logic [31:0] prog [prog_words];
logic [31:0] init_mem [data_words];
logic [31:0] ref_regs [32];
logic [31:0] ref_mem [data_words];
logic [31:0] exp_addr [$];
logic [31:0] exp_data [$];
logic [31:0] halt_pc;

function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// Upper LCG bits, the low ones repeat too quickly
function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
endfunction

function automatic logic [31:0] enc_alu(input int sel, input logic [4:0] rd,
                                        input logic [4:0] rs1, input logic [4:0] rs2);
    case (sel)
        0:       return {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
        1:       return {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
        2:       return {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
        3:       return {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
        default: return {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
    endcase
endfunction

function automatic logic [31:0] enc_i(input logic [6:0] op, input logic [11:0] imm,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {imm, rs1, f3, rd, op};
endfunction

// SW only
function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] off, input logic [4:0] rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

task automatic build_program();
    int         dump_w;
    int         k;
    logic [4:0] rd;
    logic [4:0] ra;
    logic [4:0] rb;
    logic [4:0] last_rd;
    last_rd = 5'd1;
    for (int i = 0; i < prog_words; i++) begin
        prog[i] = 32'd0;
    end
    for (int i = 0; i < data_words; i++) begin
        init_mem[i] = (i * 32'h9e3779b1) ^ 32'h6a09e667;
    end
    // Known value in every register before the random body
    for (int i = 1; i < 32; i++) begin
        prog[i - 1] = enc_i(7'b0010011, 12'(next_rand() >> 20), 5'd0, 3'b000, 5'(i));
    end
    dump_w = 31 + 200;
    for (int pc_w = 31; pc_w < dump_w; pc_w++) begin
        rd = 5'(rand_below(32));
        // Half the sources reuse the last destination
        ra = rand_below(2) == 0 ? last_rd : 5'(rand_below(32));
        rb = 5'(rand_below(32));
        k = 1 + rand_below(6);
        if (pc_w + k > dump_w) begin
            k = dump_w - pc_w;
        end
        case (rand_below(10))
            0, 1, 2, 3: prog[pc_w] = enc_alu(rand_below(5), rd, ra, rb);
            4:       prog[pc_w] = enc_i(7'b0010011, 12'(rand_below(4096)), ra, 3'b000, rd);
            5, 6:    prog[pc_w] = enc_i(7'b0000011, 12'(4 * rand_below(64)), 5'd0, 3'b010, rd);
            7:       prog[pc_w] = enc_s(12'(4 * rand_below(64)), ra, 5'd0);
            8:       prog[pc_w] = enc_b(13'(4 * k), rand_below(3) == 0 ? ra : rb, ra,
                                        rand_below(2) == 0 ? 3'b000 : 3'b001);
            default: prog[pc_w] = enc_j(21'(4 * k), rd);
        endcase
        last_rd = rd;
    end
    for (int j = 1; j < 32; j++) begin
        prog[dump_w + j - 1] = enc_s(12'(4 * (dump_base + j - 1)), 5'(j), 5'd0);
    end
    // JAL to itself, then two NOPs that only get fetched and flushed
    halt_pc = 32'(4 * (dump_w + 31));
    prog[dump_w + 31] = enc_j(21'd0, 5'd0);
    prog[dump_w + 32] = 32'h00000013;
    prog[dump_w + 33] = 32'h00000013;
endtask

task automatic run_model();
    logic [31:0] pc;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] next_pc;
    int          steps;
    for (int i = 0; i < 32; i++) begin
        ref_regs[i] = 32'd0;
    end
    for (int i = 0; i < data_words; i++) begin
        ref_mem[i] = init_mem[i];
    end
    exp_addr.delete();
    exp_data.delete();
    pc = 32'd0;
    steps = 0;
    while (pc != halt_pc && steps < 10000) begin
        ins = prog[pc[10:2]];
        a = ref_regs[ins[19:15]];
        b = ref_regs[ins[24:20]];
        next_pc = pc + 32'd4;
        case (ins[6:0])
            7'b0110011: begin
                case (ins[14:12])
                    3'b100:  ref_regs[ins[11:7]] = a ^ b;
                    3'b110:  ref_regs[ins[11:7]] = a | b;
                    3'b111:  ref_regs[ins[11:7]] = a & b;
                    default: ref_regs[ins[11:7]] = ins[30] ? a - b : a + b;
                endcase
            end
            7'b0010011: ref_regs[ins[11:7]] = a + {{20{ins[31]}}, ins[31:20]};
            7'b0000011: begin
                addr = a + {{20{ins[31]}}, ins[31:20]};
                ref_regs[ins[11:7]] = ref_mem[addr[9:2]];
            end
            7'b0100011: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                ref_mem[addr[9:2]] = b;
                exp_addr.push_back(addr);
                exp_data.push_back(b);
            end
            7'b1100011: begin
                if ((a == b) != ins[12]) begin
                    next_pc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
                end
            end
            7'b1101111: begin
                ref_regs[ins[11:7]] = pc + 32'd4;
                next_pc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            default: ;
        endcase
        ref_regs[0] = 32'd0;
        pc = next_pc;
        steps++;
    end
endtask

`endif

// File: testbench/tb_rv_core.sv
`default_nettype none

module tb_rv_core;

    `include "tb_rv_model.svh"

    logic        clk;
    logic        rst;
    logic [31:0] imem_addr;
    logic [31:0] imem_rdata;
    logic        imem_ack_n;
    logic [31:0] dmem_addr;
    logic [31:0] dmem_wdata;
    logic        dmem_req;
    logic        dmem_write;
    logic [31:0] dmem_rdata;
    logic        dmem_ack_n;

    logic [31:0] dmem [data_words];
    int          errors;
    int          store_idx;

    rv_core i_rv_core (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .imem_ack_n (imem_ack_n),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_req   (dmem_req),
        .dmem_write (dmem_write),
        .dmem_rdata (dmem_rdata),
        .dmem_ack_n (dmem_ack_n)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Read data only valid while ack_n is low
    assign imem_rdata = imem_ack_n ? 32'd0 : prog[imem_addr[10:2]];
    assign dmem_rdata = dmem_ack_n ? 32'd0 : dmem[dmem_addr[9:2]];

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("Fail %s: expected %08h, actual %08h", test, expected, actual);
    endtask

    task automatic check_reset(input string tag);
        if (imem_addr !== 32'd0) begin
            report_mismatch({tag, " reset imem_addr"}, 32'd0, imem_addr);
        end
        if (dmem_req !== 1'b0) begin
            report_mismatch({tag, " reset dmem_req"}, 32'd0, 32'(dmem_req));
        end
        if (dmem_write !== 1'b0) begin
            report_mismatch({tag, " reset dmem_write"}, 32'd0, 32'(dmem_write));
        end
    endtask

    task automatic reset_core(input string tag);
        rst = 1'b1;
        imem_ack_n = 1'b0;
        dmem_ack_n = 1'b0;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_reset(tag);
        end
        rst = 1'b0;
        // Rst is low here but no rising edge has sampled it yet
        #2;
        check_reset(tag);
    endtask

    // Store is taken at the coming rising edge
    task automatic take_store(input string tag);
        if (store_idx >= exp_addr.size()) begin
            errors++;
            $display("%s: unexpected store of %08h to %08h after all %0d expected stores",
                     tag, dmem_wdata, dmem_addr, exp_addr.size());
        end else begin
            if (dmem_addr !== exp_addr[store_idx]) begin
                report_mismatch($sformatf("%s store %0d address", tag, store_idx),
                                exp_addr[store_idx], dmem_addr);
            end
            if (dmem_wdata !== exp_data[store_idx]) begin
                report_mismatch($sformatf("%s store %0d data", tag, store_idx),
                                exp_data[store_idx], dmem_wdata);
            end
        end
        store_idx++;
        dmem[dmem_addr[9:2]] = dmem_wdata;
    endtask

    task automatic run_program(input string tag, input logic use_waits);
        int   cycles;
        int   settled;
        logic in_window;
        for (int i = 0; i < data_words; i++) begin
            dmem[i] = init_mem[i];
        end
        store_idx = 0;
        reset_core(tag);
        cycles = 0;
        settled = 0;
        while (settled < 20 && cycles < 20000) begin
            @(negedge clk);
            if (use_waits) begin
                imem_ack_n = (next_rand() >> 30) == 32'd0;
                dmem_ack_n = (next_rand() >> 30) == 32'd0;
            end
            if (dmem_req && dmem_write && !dmem_ack_n) begin
                take_store(tag);
            end
            // The halt loop cycles the PC over three words
            in_window = imem_addr >= halt_pc && imem_addr <= halt_pc + 32'd8;
            if (!in_window) begin
                settled = 0;
            end else if (!imem_ack_n && !dmem_ack_n) begin
                settled++;
            end
            cycles++;
        end
        if (settled < 20) begin
            errors++;
            $display("%s: core did not reach the halt loop within 20000 cycles", tag);
        end else begin
            if (store_idx < exp_addr.size()) begin
                errors++;
                $display("%s: only %0d of %0d expected stores appeared on the bus",
                         tag, store_idx, exp_addr.size());
            end
            for (int i = 0; i < dump_base + 31; i++) begin
                if (dmem[i] !== ref_mem[i]) begin
                    report_mismatch($sformatf("%s final word %0d", tag, i),
                                    ref_mem[i], dmem[i]);
                end
            end
        end
    endtask

    initial begin
        errors = 0;
        store_idx = 0;
        rst = 1'b1;
        imem_ack_n = 1'b0;
        dmem_ack_n = 1'b0;
        lcg_state = 32'hd5c4f290;
        build_program();
        run_model();
        run_program("wait_states", 1'b1);
        run_program("no_waits", 1'b0);
        $display("Errors: %0d, expected stores per run: %0d", errors, exp_addr.size());
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/rv_core.sv
`default_nettype none

module rv_core import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    // Instruction memory
    output logic [31:0] imem_addr,
    input  logic [31:0] imem_rdata,
    input  logic        imem_ack_n,

    // Data memory
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_req,
    output logic        dmem_write,
    input  logic [31:0] dmem_rdata,
    input  logic        dmem_ack_n
);

    if_id_t      if_id;
    id_ex_t      id_ex;
    ex_mem_t     ex_mem;
    wb_t         wb;
    logic        freeze;
    logic        stall;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    fwd_sel_t    fwd_a;
    fwd_sel_t    fwd_b;
    logic [31:0] mem_fwd_value;

    rv_fetch i_rv_fetch (
        .clk         (clk),
        .rst         (rst),
        .freeze      (freeze),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_addr   (imem_addr),
        .imem_rdata  (imem_rdata),
        .if_id       (if_id)
    );

    rv_decode i_rv_decode (
        .clk      (clk),
        .rst      (rst),
        .freeze   (freeze),
        .stall    (stall),
        .redirect (redirect),
        .if_id    (if_id),
        .wb       (wb),
        .id_ex    (id_ex),
        .rs1      (rs1),
        .rs2      (rs2)
    );

    rv_hazard i_rv_hazard (
        .rs1        (rs1),
        .rs2        (rs2),
        .id_ex      (id_ex),
        .ex_mem     (ex_mem),
        .wb         (wb),
        .imem_ack_n (imem_ack_n),
        .dmem_ack_n (dmem_ack_n),
        .stall      (stall),
        .freeze     (freeze),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b)
    );

    rv_execute i_rv_execute (
        .clk           (clk),
        .rst           (rst),
        .freeze        (freeze),
        .id_ex         (id_ex),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .mem_fwd_value (mem_fwd_value),
        .wb            (wb),
        .redirect      (redirect),
        .redirect_pc   (redirect_pc),
        .ex_mem        (ex_mem)
    );

    rv_memory i_rv_memory (
        .clk           (clk),
        .rst           (rst),
        .freeze        (freeze),
        .ex_mem        (ex_mem),
        .dmem_addr     (dmem_addr),
        .dmem_wdata    (dmem_wdata),
        .dmem_req      (dmem_req),
        .dmem_write    (dmem_write),
        .dmem_rdata    (dmem_rdata),
        .dmem_ack_n    (dmem_ack_n),
        .mem_fwd_value (mem_fwd_value),
        .wb            (wb)
    );

endmodule

`default_nettype wire

// File: verilog/rv_decode.sv
`default_nettype none

module rv_decode import rv_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       freeze,
    input  logic       stall,
    input  logic       redirect,
    input  if_id_t     if_id,
    input  wb_t        wb,
    output id_ex_t     id_ex,
    output logic [4:0] rs1,
    output logic [4:0] rs2
);

    logic [31:0] regs [32];
    rv_instr_t   instr;
    id_ex_t      id_next;
    logic        use_rs1;
    logic        use_rs2;

    assign instr = if_id.instr;

    // x0 reads zero, a write in this cycle passes straight through
    function automatic logic [31:0] read_reg(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (wb.write && wb.rd == addr) begin
            return wb.value;
        end
        return regs[addr];
    endfunction

    function automatic alu_op_t alu_of(input logic [2:0] funct3, input logic sub);
        case (funct3)
            3'b000:  return sub ? alu_sub : alu_add;
            3'b100:  return alu_xor;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (wb.write && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.value;
        end
    end

    always_comb begin
        id_next = '0;
        id_next.pc = if_id.pc;
        id_next.pc4 = if_id.pc4;
        id_next.rd = instr.r_fmt.rd;
        id_next.alu_op = alu_add;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        if (if_id.valid) begin
            case (instr.r_fmt.opcode)
                op_reg: begin
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    id_next.reg_write = 1'b1;
                    id_next.alu_op = alu_of(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
                end
                op_imm: begin
                    use_rs1 = 1'b1;
                    id_next.uses_imm = 1'b1;
                    id_next.reg_write = 1'b1;
                    id_next.imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
                    id_next.alu_op = alu_of(instr.i_fmt.funct3, 1'b0);
                end
                op_load: begin
                    use_rs1 = 1'b1;
                    id_next.uses_imm = 1'b1;
                    id_next.is_load = 1'b1;
                    id_next.reg_write = 1'b1;
                    id_next.imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
                end
                op_store: begin
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    id_next.uses_imm = 1'b1;
                    id_next.is_store = 1'b1;
                    id_next.imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
                                   instr.s_fmt.imm_lo};
                end
                op_branch: begin
                    use_rs1 = 1'b1;
                    use_rs2 = 1'b1;
                    id_next.is_branch = 1'b1;
                    id_next.branch_ne = instr.b_fmt.funct3[0];
                    id_next.imm = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12,
                                   instr.b_fmt.imm11, instr.b_fmt.imm10_5,
                                   instr.b_fmt.imm4_1, 1'b0};
                end
                op_jal: begin
                    id_next.is_jal = 1'b1;
                    id_next.reg_write = 1'b1;
                    id_next.imm = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20,
                                   instr.j_fmt.imm19_12, instr.j_fmt.imm11,
                                   instr.j_fmt.imm10_1, 1'b0};
                end
                default: ;
            endcase
        end
        // Unused sources read as x0 so they never match a hazard
        rs1 = use_rs1 ? instr.r_fmt.rs1 : 5'd0;
        rs2 = use_rs2 ? instr.r_fmt.rs2 : 5'd0;
        id_next.rs1 = rs1;
        id_next.rs2 = rs2;
        id_next.rs1_val = read_reg(rs1);
        id_next.rs2_val = read_reg(rs2);
    end

    always_ff @(posedge clk) begin
        if (rst || !freeze) begin
            id_ex <= id_next;
            // Bubble into execute
            if (rst || stall || redirect) begin
                id_ex.is_load <= 1'b0;
                id_ex.is_store <= 1'b0;
                id_ex.is_branch <= 1'b0;
                id_ex.is_jal <= 1'b0;
                id_ex.reg_write <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_execute.sv
`default_nettype none

module rv_execute import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        freeze,
    input  id_ex_t      id_ex,
    input  fwd_sel_t    fwd_a,
    input  fwd_sel_t    fwd_b,
    input  logic [31:0] mem_fwd_value,
    input  wb_t         wb,
    output logic        redirect,
    output logic [31:0] redirect_pc,
    output ex_mem_t     ex_mem
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_b;
    logic [31:0] result;
    logic        taken;

    function automatic logic [31:0] pick(input fwd_sel_t sel, input logic [31:0] reg_val);
        case (sel)
            fwd_mem: return mem_fwd_value;
            fwd_wb:  return wb.value;
            default: return reg_val;
        endcase
    endfunction

    always_comb begin
        op_a = pick(fwd_a, id_ex.rs1_val);
        op_b = pick(fwd_b, id_ex.rs2_val);
        alu_b = id_ex.uses_imm ? id_ex.imm : op_b;
        case (id_ex.alu_op)
            alu_sub: result = op_a - alu_b;
            alu_and: result = op_a & alu_b;
            alu_or:  result = op_a | alu_b;
            alu_xor: result = op_a ^ alu_b;
            default: result = op_a + alu_b;
        endcase
    end

    // BEQ and BNE compare the register operands
    assign taken = id_ex.is_branch && ((op_a == op_b) != id_ex.branch_ne);
    assign redirect = taken || id_ex.is_jal;
    assign redirect_pc = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem.is_load <= 1'b0;
            ex_mem.is_store <= 1'b0;
            ex_mem.is_jal <= 1'b0;
            ex_mem.reg_write <= 1'b0;
        end else if (!freeze) begin
            ex_mem.pc4 <= id_ex.pc4;
            ex_mem.result <= result;
            ex_mem.store_data <= op_b;
            ex_mem.rd <= id_ex.rd;
            ex_mem.is_load <= id_ex.is_load;
            ex_mem.is_store <= id_ex.is_store;
            ex_mem.is_jal <= id_ex.is_jal;
            ex_mem.reg_write <= id_ex.reg_write;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_fetch.sv
`default_nettype none

module rv_fetch import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        freeze,
    input  logic        stall,
    input  logic        redirect,
    input  logic [31:0] redirect_pc,
    output logic [31:0] imem_addr,
    input  rv_instr_t   imem_rdata,
    output if_id_t      if_id
);

    logic [31:0] pc;
    logic [31:0] pc4;

    assign pc4 = pc + 32'd4;
    // Instruction bus reads the current PC every cycle
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= 32'd0;
            if_id.valid <= 1'b0;
        end else if (!freeze) begin
            if (redirect) begin
                pc <= redirect_pc;
                // Squash the word fetched down the wrong path
                if_id.valid <= 1'b0;
            end else if (!stall) begin
                pc <= pc4;
                if_id.pc <= pc;
                if_id.pc4 <= pc4;
                if_id.instr <= imem_rdata;
                if_id.valid <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rv_hazard.sv
`default_nettype none

module rv_hazard import rv_pkg::*; (
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  id_ex_t     id_ex,
    input  ex_mem_t    ex_mem,
    input  wb_t        wb,
    input  logic       imem_ack_n,
    input  logic       dmem_ack_n,
    output logic       stall,
    output logic       freeze,
    output fwd_sel_t   fwd_a,
    output fwd_sel_t   fwd_b
);

    // Youngest producer wins
    function automatic fwd_sel_t select(input logic [4:0] src);
        if (ex_mem.reg_write && ex_mem.rd != 5'd0 && ex_mem.rd == src) begin
            return fwd_mem;
        end
        if (wb.write && wb.rd != 5'd0 && wb.rd == src) begin
            return fwd_wb;
        end
        return fwd_none;
    endfunction

    always_comb begin
        fwd_a = select(id_ex.rs1);
        fwd_b = select(id_ex.rs2);
    end

    // Load data is only ready once the load leaves memory
    assign stall = id_ex.is_load && id_ex.rd != 5'd0 &&
                   (id_ex.rd == rs1 || id_ex.rd == rs2);

    assign freeze = imem_ack_n || dmem_ack_n;

endmodule

`default_nettype wire

// File: verilog/rv_memory.sv
`default_nettype none

module rv_memory import rv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        freeze,
    input  ex_mem_t     ex_mem,
    output logic [31:0] dmem_addr,
    output logic [31:0] dmem_wdata,
    output logic        dmem_req,
    output logic        dmem_write,
    input  logic [31:0] dmem_rdata,
    input  logic        dmem_ack_n,
    output logic [31:0] mem_fwd_value,
    output wb_t         wb
);

    mem_wb_t     mem_wb;
    logic        mem_done;
    logic [31:0] load_hold;
    logic [31:0] load_value;

    // Access finished but the other bus still holds the pipeline
    always_ff @(posedge clk) begin
        if (rst || !freeze) begin
            mem_done <= 1'b0;
        end else if (dmem_req && !dmem_ack_n) begin
            mem_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (dmem_req && !dmem_ack_n) begin
            load_hold <= dmem_rdata;
        end
    end

    assign dmem_addr = ex_mem.result;
    assign dmem_wdata = ex_mem.store_data;
    assign dmem_req = (ex_mem.is_load || ex_mem.is_store) && !mem_done;
    assign dmem_write = ex_mem.is_store && !mem_done;

    assign load_value = mem_done ? load_hold : dmem_rdata;
    assign mem_fwd_value = ex_mem.is_jal ? ex_mem.pc4 : ex_mem.result;

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_wb.reg_write <= 1'b0;
        end else if (!freeze) begin
            mem_wb.wb_value <= ex_mem.is_load ? load_value : mem_fwd_value;
            mem_wb.rd <= ex_mem.rd;
            mem_wb.reg_write <= ex_mem.reg_write;
        end
    end

    assign wb.rd = mem_wb.rd;
    assign wb.value = mem_wb.wb_value;
    assign wb.write = mem_wb.reg_write;

endmodule

`default_nettype wire

// File: verilog/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // Branch offset bits as scattered by the encoding
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } rv_instr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_none,
        fwd_mem,
        fwd_wb
    } fwd_sel_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc4;
        rv_instr_t   instr;
        logic        valid;
    } if_id_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] pc4;
        logic [31:0] rs1_val;
        logic [31:0] rs2_val;
        logic [31:0] imm;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  rd;
        alu_op_t     alu_op;
        logic        uses_imm;
        logic        is_load;
        logic        is_store;
        logic        is_branch;
        logic        branch_ne;
        logic        is_jal;
        logic        reg_write;
    } id_ex_t;

    typedef struct packed {
        logic [31:0] pc4;
        logic [31:0] result;
        logic [31:0] store_data;
        logic [4:0]  rd;
        logic        is_load;
        logic        is_store;
        logic        is_jal;
        logic        reg_write;
    } ex_mem_t;

    typedef struct packed {
        logic [31:0] wb_value;
        logic [4:0]  rd;
        logic        reg_write;
    } mem_wb_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] value;
        logic        write;
    } wb_t;

endpackage

`default_nettype wire

// File: vlog.f
+incdir+testbench
verilog/rv_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_hazard.sv
verilog/rv_execute.sv
verilog/rv_memory.sv
verilog/rv_core.sv
testbench/tb_rv_core.sv
